// ==== verilog/battle_pkg.sv ====
`default_nettype none

package battle_pkg;

	// screen and datapath widths
	localparam int x_width = 8;
	localparam int y_width = 7;
	localparam int colour_width = 6;
	localparam int health_width = 4;
	localparam int damage_width = 2;

	typedef enum logic [1:0] {
		species_none,
		species_grass,
		species_fire,
		species_water
	} species_t;

	typedef enum logic [1:0] {
		msg_none,
		msg_not_effective,
		msg_hit,
		msg_super_effective
	} msg_t;

	typedef enum logic [2:0] {
		draw_idle,
		draw_sprite_p1,
		draw_sprite_p2,
		draw_message,
		draw_background,
		draw_winner
	} draw_t;

	localparam logic [health_width-1:0] health_full = 4'd9;

	localparam logic [damage_width-1:0] damage_tackle = 2'd2;
	localparam logic [damage_width-1:0] damage_super = 2'd3;
	localparam logic [damage_width-1:0] damage_neutral = 2'd2;
	localparam logic [damage_width-1:0] damage_weak = 2'd1;

	// species that each species beats, indexed by attacker
	localparam species_t type_prey [4] = '{species_none, species_water, species_grass, species_fire};

	// area sizes and screen offsets
	localparam int sprite_w = 64;
	localparam int sprite_h = 42;
	localparam logic [x_width-1:0] sprite_x0_p1 = 8'd0;
	localparam logic [x_width-1:0] sprite_x0_p2 = 8'd96;
	localparam logic [y_width-1:0] sprite_y0 = 7'd46;
	localparam int msg_w = 152;
	localparam int msg_h = 42;
	localparam logic [x_width-1:0] msg_x0 = 8'd4;
	localparam logic [y_width-1:0] msg_y0 = 7'd78;
	localparam int screen_w = 160;
	localparam int screen_h = 120;

	// palette, two bits per channel as rrggbb
	localparam logic [colour_width-1:0] colour_grass = 6'b001100;
	localparam logic [colour_width-1:0] colour_fire = 6'b110000;
	localparam logic [colour_width-1:0] colour_water = 6'b000011;
	localparam logic [colour_width-1:0] colour_background = 6'b010101;
	localparam logic [colour_width-1:0] colour_msg_weak = 6'b101010;
	localparam logic [colour_width-1:0] colour_msg_hit = 6'b111100;
	localparam logic [colour_width-1:0] colour_msg_super = 6'b110011;
	localparam logic [colour_width-1:0] colour_win_p1 = 6'b001111;
	localparam logic [colour_width-1:0] colour_win_p2 = 6'b111000;

	// active low segments gfedcba, showing digits 0 to 3
	localparam logic [6:0] seg_none = 7'b1000000;
	localparam logic [6:0] seg_grass = 7'b1111001;
	localparam logic [6:0] seg_fire = 7'b0100100;
	localparam logic [6:0] seg_water = 7'b0110000;

endpackage

`default_nettype wire

// ==== verilog/species_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module species_select (
	input logic clock,
	input logic resetn,
	input logic p1_pick,
	input logic p2_pick,
	input battle_pkg::species_t pick_species,
	output battle_pkg::species_t p1_species,
	output battle_pkg::species_t p2_species,
	output logic [6:0] pokemon_p1,
	output logic [6:0] pokemon_p2
);

	// one table for both displays
	function automatic logic [6:0] seg_code(input battle_pkg::species_t species);
		case (species)
			battle_pkg::species_grass: seg_code = battle_pkg::seg_grass;
			battle_pkg::species_fire: seg_code = battle_pkg::seg_fire;
			battle_pkg::species_water: seg_code = battle_pkg::seg_water;
			default: seg_code = battle_pkg::seg_none;
		endcase
	endfunction

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			p1_species <= battle_pkg::species_none;
			p2_species <= battle_pkg::species_none;
		end
		else
		begin
			if (p1_pick)
				p1_species <= pick_species;
			if (p2_pick)
				p2_species <= pick_species;
		end
	end

	// follows the latched choice, so new code shows one cycle after the strobe
	assign pokemon_p1 = seg_code(p1_species);
	assign pokemon_p2 = seg_code(p2_species);

	// players take turns choosing
	pick_one_player: assert property (@(posedge clock) disable iff (!resetn)
		!(p1_pick && p2_pick))
		else $error("p1_pick and p2_pick high in the same cycle");

endmodule

`default_nettype wire

// ==== verilog/damage_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

module damage_calc (
	input logic clock,
	input logic resetn,
	input battle_pkg::species_t p1_species,
	input battle_pkg::species_t p2_species,
	input logic p1_tackle,
	input logic p1_special,
	input logic p2_tackle,
	input logic p2_special,
	output logic dmg_valid,
	output logic dmg_to_p2,
	output logic [battle_pkg::damage_width-1:0] dmg_amount,
	output battle_pkg::msg_t last_msg
);

	logic hit;
	logic to_p2;
	logic special;
	battle_pkg::species_t attacker;
	battle_pkg::species_t defender;
	battle_pkg::msg_t next_msg;
	logic [battle_pkg::damage_width-1:0] next_dmg;

	function automatic logic beats(input battle_pkg::species_t a, input battle_pkg::species_t d);
		beats = (a != battle_pkg::species_none) && (battle_pkg::type_prey[a] == d);
	endfunction

	always_comb
	begin
		hit = p1_tackle || p1_special || p2_tackle || p2_special;
		// player 1 wins a tie
		to_p2 = p1_tackle || p1_special;
		special = to_p2 ? p1_special : p2_special;
		attacker = to_p2 ? p1_species : p2_species;
		defender = to_p2 ? p2_species : p1_species;

		if (!special)
		begin
			next_msg = battle_pkg::msg_hit;
			next_dmg = battle_pkg::damage_tackle;
		end
		else if (beats(attacker, defender))
		begin
			next_msg = battle_pkg::msg_super_effective;
			next_dmg = battle_pkg::damage_super;
		end
		else if (beats(defender, attacker))
		begin
			next_msg = battle_pkg::msg_not_effective;
			next_dmg = battle_pkg::damage_weak;
		end
		else
		begin
			next_msg = battle_pkg::msg_hit;
			next_dmg = battle_pkg::damage_neutral;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			dmg_valid <= 1'b0;
			last_msg <= battle_pkg::msg_none;
		end
		else
		begin
			dmg_valid <= hit;
			// message stays up until the next attack
			if (hit)
				last_msg <= next_msg;
		end
	end

	always_ff @(posedge clock)
	begin
		dmg_to_p2 <= to_p2;
		dmg_amount <= next_dmg;
	end

	// a player picks one move per turn
	one_move_per_player: assert property (@(posedge clock) disable iff (!resetn)
		!(p1_tackle && p1_special) && !(p2_tackle && p2_special))
		else $error("tackle and special from the same player in one cycle");

endmodule

`default_nettype wire

// ==== verilog/health_keeper.sv ====
`timescale 1ns/1ps
`default_nettype none

module health_keeper (
	input logic clock,
	input logic resetn,
	input logic p1_pick,
	input logic dmg_valid,
	input logic dmg_to_p2,
	input logic [battle_pkg::damage_width-1:0] dmg_amount,
	output logic [battle_pkg::health_width-1:0] display_p1_health,
	output logic [battle_pkg::health_width-1:0] display_p2_health,
	output logic p1_wins,
	output logic p2_wins,
	output logic [1:0] winner
);

	logic [battle_pkg::health_width-1:0] p1_health;
	logic [battle_pkg::health_width-1:0] p2_health;

	// clamps at zero instead of wrapping round to 15
	function automatic logic [battle_pkg::health_width-1:0] sat_sub(
		input logic [battle_pkg::health_width-1:0] health,
		input logic [battle_pkg::damage_width-1:0] damage
	);
		logic [battle_pkg::health_width-1:0] wide_damage;
		wide_damage = {{(battle_pkg::health_width - battle_pkg::damage_width){1'b0}}, damage};
		if (wide_damage >= health)
			sat_sub = '0;
		else
			sat_sub = health - wide_damage;
	endfunction

	always_ff @(posedge clock)
	begin
		if (!resetn || p1_pick)
		begin
			// new game starts on player 1's pick
			p1_health <= battle_pkg::health_full;
			p2_health <= battle_pkg::health_full;
		end
		else if (dmg_valid)
		begin
			if (dmg_to_p2)
				p2_health <= sat_sub(p2_health, dmg_amount);
			else
				p1_health <= sat_sub(p1_health, dmg_amount);
		end
	end

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			p1_wins <= 1'b0;
			p2_wins <= 1'b0;
		end
		else
		begin
			p1_wins <= (p2_health == '0);
			p2_wins <= (p2_health != '0) && (p1_health == '0);
		end
	end

	assign display_p1_health = p1_health;
	assign display_p2_health = p2_health;
	// bit 0 for player 1, bit 1 for player 2
	assign winner = {p2_wins, p1_wins};

	health_in_range: assert property (@(posedge clock) disable iff (!resetn)
		(p1_health <= battle_pkg::health_full) && (p2_health <= battle_pkg::health_full))
		else $error("health above health_full: p1 %0d p2 %0d", p1_health, p2_health);

endmodule

`default_nettype wire

// ==== verilog/region_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module region_scanner #(
	parameter int x_max = battle_pkg::screen_w,
	parameter int y_max = battle_pkg::screen_h
) (
	input logic clock,
	input logic resetn,
	input logic enable,
	output logic [battle_pkg::x_width-1:0] x_count,
	output logic [battle_pkg::y_width-1:0] y_count
);

	logic x_last;
	logic y_last;

	assign x_last = (x_count == battle_pkg::x_width'(x_max - 1));
	assign y_last = (y_count == battle_pkg::y_width'(y_max - 1));

	always_ff @(posedge clock)
	begin
		if (!resetn || !enable)
		begin
			// parked at the area origin
			x_count <= '0;
			y_count <= '0;
		end
		else if (x_last)
		begin
			x_count <= '0;
			// end of area wraps back to the first row
			if (y_last)
				y_count <= '0;
			else
				y_count <= y_count + 1'b1;
		end
		else
		begin
			x_count <= x_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pixel_painter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_painter (
	input logic clock,
	input logic resetn,
	input battle_pkg::draw_t draw_mode,
	input logic [battle_pkg::x_width-1:0] sprite_x,
	input logic [battle_pkg::y_width-1:0] sprite_y,
	input logic [battle_pkg::x_width-1:0] msg_x,
	input logic [battle_pkg::y_width-1:0] msg_y,
	input logic [battle_pkg::x_width-1:0] screen_x,
	input logic [battle_pkg::y_width-1:0] screen_y,
	input battle_pkg::species_t p1_species,
	input battle_pkg::species_t p2_species,
	input battle_pkg::msg_t last_msg,
	input logic [1:0] winner,
	output logic [battle_pkg::x_width-1:0] x_data,
	output logic [battle_pkg::y_width-1:0] y_data,
	output logic [battle_pkg::colour_width-1:0] colour,
	output logic pixel_valid
);

	logic [battle_pkg::x_width-1:0] next_x;
	logic [battle_pkg::y_width-1:0] next_y;
	logic [battle_pkg::colour_width-1:0] next_colour;
	logic next_valid;

	function automatic logic [battle_pkg::colour_width-1:0] species_colour(
		input battle_pkg::species_t species
	);
		case (species)
			battle_pkg::species_grass: species_colour = battle_pkg::colour_grass;
			battle_pkg::species_fire: species_colour = battle_pkg::colour_fire;
			battle_pkg::species_water: species_colour = battle_pkg::colour_water;
			default: species_colour = battle_pkg::colour_background;
		endcase
	endfunction

	function automatic logic [battle_pkg::colour_width-1:0] msg_colour(input battle_pkg::msg_t msg);
		case (msg)
			battle_pkg::msg_not_effective: msg_colour = battle_pkg::colour_msg_weak;
			battle_pkg::msg_hit: msg_colour = battle_pkg::colour_msg_hit;
			battle_pkg::msg_super_effective: msg_colour = battle_pkg::colour_msg_super;
			default: msg_colour = battle_pkg::colour_background;
		endcase
	endfunction

	always_comb
	begin
		next_x = screen_x;
		next_y = screen_y;
		next_colour = battle_pkg::colour_background;
		next_valid = 1'b1;
		case (draw_mode)
			battle_pkg::draw_sprite_p1:
			begin
				next_x = sprite_x + battle_pkg::sprite_x0_p1;
				next_y = sprite_y + battle_pkg::sprite_y0;
				next_colour = species_colour(p1_species);
			end
			battle_pkg::draw_sprite_p2:
			begin
				next_x = sprite_x + battle_pkg::sprite_x0_p2;
				next_y = sprite_y + battle_pkg::sprite_y0;
				next_colour = species_colour(p2_species);
			end
			battle_pkg::draw_message:
			begin
				next_x = msg_x + battle_pkg::msg_x0;
				next_y = msg_y + battle_pkg::msg_y0;
				next_colour = msg_colour(last_msg);
			end
			battle_pkg::draw_background: next_colour = battle_pkg::colour_background;
			battle_pkg::draw_winner:
			begin
				if (winner[0])
					next_colour = battle_pkg::colour_win_p1;
				else if (winner[1])
					next_colour = battle_pkg::colour_win_p2;
			end
			default: next_valid = 1'b0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!resetn)
			pixel_valid <= 1'b0;
		else
			pixel_valid <= next_valid;
	end

	always_ff @(posedge clock)
	begin
		x_data <= next_x;
		y_data <= next_y;
		colour <= next_colour;
	end

	// offsets plus scanner limits must keep every pixel on the framebuffer
	pixel_on_screen: assert property (@(posedge clock) disable iff (!resetn)
		pixel_valid |-> (x_data < battle_pkg::screen_w) && (y_data < battle_pkg::screen_h))
		else $error("pixel off screen at (%0d, %0d)", x_data, y_data);

endmodule

`default_nettype wire

// ==== verilog/battle_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module battle_datapath (
	input logic clock,
	input logic resetn,
	input logic p1_pick,
	input logic p2_pick,
	input battle_pkg::species_t pick_species,
	input logic p1_tackle,
	input logic p1_special,
	input logic p2_tackle,
	input logic p2_special,
	input battle_pkg::draw_t draw_mode,
	output logic [battle_pkg::x_width-1:0] x_data,
	output logic [battle_pkg::y_width-1:0] y_data,
	output logic [battle_pkg::colour_width-1:0] colour,
	output logic pixel_valid,
	output logic [battle_pkg::health_width-1:0] display_p1_health,
	output logic [battle_pkg::health_width-1:0] display_p2_health,
	output logic p1_wins,
	output logic p2_wins,
	output logic [6:0] pokemon_p1,
	output logic [6:0] pokemon_p2
);

	battle_pkg::species_t p1_species;
	battle_pkg::species_t p2_species;
	battle_pkg::msg_t last_msg;
	logic dmg_valid;
	logic dmg_to_p2;
	logic [battle_pkg::damage_width-1:0] dmg_amount;
	logic [1:0] winner;

	logic sprite_en;
	logic msg_en;
	logic screen_en;
	logic [battle_pkg::x_width-1:0] sprite_x;
	logic [battle_pkg::y_width-1:0] sprite_y;
	logic [battle_pkg::x_width-1:0] msg_x;
	logic [battle_pkg::y_width-1:0] msg_y;
	logic [battle_pkg::x_width-1:0] screen_x;
	logic [battle_pkg::y_width-1:0] screen_y;

	// battle chain
	species_select u_species_select (
		.clock(clock), .resetn(resetn), .p1_pick(p1_pick), .p2_pick(p2_pick),
		.pick_species(pick_species), .p1_species(p1_species), .p2_species(p2_species),
		.pokemon_p1(pokemon_p1), .pokemon_p2(pokemon_p2)
	);

	damage_calc u_damage_calc (
		.clock(clock), .resetn(resetn), .p1_species(p1_species), .p2_species(p2_species),
		.p1_tackle(p1_tackle), .p1_special(p1_special), .p2_tackle(p2_tackle),
		.p2_special(p2_special), .dmg_valid(dmg_valid), .dmg_to_p2(dmg_to_p2),
		.dmg_amount(dmg_amount), .last_msg(last_msg)
	);

	health_keeper u_health_keeper (
		.clock(clock), .resetn(resetn), .p1_pick(p1_pick), .dmg_valid(dmg_valid),
		.dmg_to_p2(dmg_to_p2), .dmg_amount(dmg_amount),
		.display_p1_health(display_p1_health), .display_p2_health(display_p2_health),
		.p1_wins(p1_wins), .p2_wins(p2_wins), .winner(winner)
	);

	// raster chain, both sprites share one scanner
	assign sprite_en = (draw_mode == battle_pkg::draw_sprite_p1) ||
		(draw_mode == battle_pkg::draw_sprite_p2);
	assign msg_en = (draw_mode == battle_pkg::draw_message);
	assign screen_en = (draw_mode == battle_pkg::draw_background) ||
		(draw_mode == battle_pkg::draw_winner);

	region_scanner #(.x_max(battle_pkg::sprite_w), .y_max(battle_pkg::sprite_h)) u_sprite_scan (
		.clock(clock), .resetn(resetn), .enable(sprite_en), .x_count(sprite_x), .y_count(sprite_y)
	);

	region_scanner #(.x_max(battle_pkg::msg_w), .y_max(battle_pkg::msg_h)) u_msg_scan (
		.clock(clock), .resetn(resetn), .enable(msg_en), .x_count(msg_x), .y_count(msg_y)
	);

	region_scanner #(.x_max(battle_pkg::screen_w), .y_max(battle_pkg::screen_h)) u_screen_scan (
		.clock(clock), .resetn(resetn), .enable(screen_en), .x_count(screen_x), .y_count(screen_y)
	);

	pixel_painter u_pixel_painter (
		.clock(clock), .resetn(resetn), .draw_mode(draw_mode),
		.sprite_x(sprite_x), .sprite_y(sprite_y), .msg_x(msg_x), .msg_y(msg_y),
		.screen_x(screen_x), .screen_y(screen_y), .p1_species(p1_species),
		.p2_species(p2_species), .last_msg(last_msg), .winner(winner),
		.x_data(x_data), .y_data(y_data), .colour(colour), .pixel_valid(pixel_valid)
	);

endmodule

`default_nettype wire

// ==== sim/tb_battle.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_battle;

	logic clock;
	logic resetn;
	logic p1_pick;
	logic p2_pick;
	battle_pkg::species_t pick_species;
	logic p1_tackle;
	logic p1_special;
	logic p2_tackle;
	logic p2_special;
	battle_pkg::draw_t draw_mode;
	logic [battle_pkg::x_width-1:0] x_data;
	logic [battle_pkg::y_width-1:0] y_data;
	logic [battle_pkg::colour_width-1:0] colour;
	logic pixel_valid;
	logic [battle_pkg::health_width-1:0] display_p1_health;
	logic [battle_pkg::health_width-1:0] display_p2_health;
	logic p1_wins;
	logic p2_wins;
	logic [6:0] pokemon_p1;
	logic [6:0] pokemon_p2;

	// reference model state
	battle_pkg::species_t exp_p1_species;
	battle_pkg::species_t exp_p2_species;
	battle_pkg::msg_t exp_msg;
	logic hit_q;
	logic to_p2_q;
	logic [battle_pkg::damage_width-1:0] amount_q;
	logic [battle_pkg::health_width-1:0] exp_p1_health;
	logic [battle_pkg::health_width-1:0] exp_p2_health;
	logic exp_p1_wins;
	logic exp_p2_wins;
	logic exp_valid;
	logic [battle_pkg::x_width-1:0] exp_x;
	logic [battle_pkg::y_width-1:0] exp_y;
	logic [battle_pkg::colour_width-1:0] exp_colour;
	battle_pkg::draw_t exp_shown;
	int scan_area;
	int scan_x;
	int scan_y;
	logic [6:0] exp_seg_p1;
	logic [6:0] exp_seg_p2;
	logic [31:0] lfsr;

	battle_datapath DUT (.*);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0])
			lfsr_step = (state >> 1) ^ 32'h8020_0003;
		else
			lfsr_step = state >> 1;
	endfunction

	// grass beats water, water beats fire, fire beats grass
	function automatic logic chart_win(input battle_pkg::species_t a, input battle_pkg::species_t d);
		return (a == battle_pkg::species_grass && d == battle_pkg::species_water) ||
			(a == battle_pkg::species_water && d == battle_pkg::species_fire) ||
			(a == battle_pkg::species_fire && d == battle_pkg::species_grass);
	endfunction

	function automatic logic [1:0] attack_damage(input battle_pkg::species_t a,
		input battle_pkg::species_t d, input logic special);
		if (!special)
			return battle_pkg::damage_tackle;
		if (chart_win(a, d))
			return battle_pkg::damage_super;
		if (chart_win(d, a))
			return battle_pkg::damage_weak;
		return battle_pkg::damage_neutral;
	endfunction

	function automatic battle_pkg::msg_t attack_message(input battle_pkg::species_t a,
		input battle_pkg::species_t d, input logic special);
		if (!special)
			return battle_pkg::msg_hit;
		if (chart_win(a, d))
			return battle_pkg::msg_super_effective;
		if (chart_win(d, a))
			return battle_pkg::msg_not_effective;
		return battle_pkg::msg_hit;
	endfunction

	function automatic logic [3:0] health_after(input logic [3:0] health, input logic [1:0] dmg);
		return (health > dmg) ? health - dmg : 4'd0;
	endfunction

	function automatic logic [6:0] expected_segments(input battle_pkg::species_t s);
		if (s == battle_pkg::species_grass)
			return battle_pkg::seg_grass;
		if (s == battle_pkg::species_fire)
			return battle_pkg::seg_fire;
		if (s == battle_pkg::species_water)
			return battle_pkg::seg_water;
		return battle_pkg::seg_none;
	endfunction

	function automatic logic [5:0] colour_of_species(input battle_pkg::species_t s);
		if (s == battle_pkg::species_grass)
			return battle_pkg::colour_grass;
		if (s == battle_pkg::species_fire)
			return battle_pkg::colour_fire;
		if (s == battle_pkg::species_water)
			return battle_pkg::colour_water;
		return battle_pkg::colour_background;
	endfunction

	function automatic logic [5:0] colour_of_mode(input battle_pkg::draw_t mode);
		case (mode)
			battle_pkg::draw_sprite_p1: return colour_of_species(exp_p1_species);
			battle_pkg::draw_sprite_p2: return colour_of_species(exp_p2_species);
			battle_pkg::draw_message:
			begin
				if (exp_msg == battle_pkg::msg_not_effective)
					return battle_pkg::colour_msg_weak;
				if (exp_msg == battle_pkg::msg_hit)
					return battle_pkg::colour_msg_hit;
				if (exp_msg == battle_pkg::msg_super_effective)
					return battle_pkg::colour_msg_super;
				return battle_pkg::colour_background;
			end
			battle_pkg::draw_winner:
			begin
				if (exp_p1_wins)
					return battle_pkg::colour_win_p1;
				if (exp_p2_wins)
					return battle_pkg::colour_win_p2;
				return battle_pkg::colour_background;
			end
			default: return battle_pkg::colour_background;
		endcase
	endfunction

	// 1 sprite, 2 message, 3 full screen, 0 nothing
	function automatic int area_of(input battle_pkg::draw_t mode);
		case (mode)
			battle_pkg::draw_sprite_p1, battle_pkg::draw_sprite_p2: return 1;
			battle_pkg::draw_message: return 2;
			battle_pkg::draw_background, battle_pkg::draw_winner: return 3;
			default: return 0;
		endcase
	endfunction

	function automatic int area_width(input int area);
		return (area == 1) ? battle_pkg::sprite_w : (area == 2) ? battle_pkg::msg_w : battle_pkg::screen_w;
	endfunction

	function automatic int area_height(input int area);
		return (area == 1) ? battle_pkg::sprite_h : (area == 2) ? battle_pkg::msg_h : battle_pkg::screen_h;
	endfunction

	function automatic int x_offset(input battle_pkg::draw_t mode);
		if (mode == battle_pkg::draw_sprite_p1)
			return battle_pkg::sprite_x0_p1;
		if (mode == battle_pkg::draw_sprite_p2)
			return battle_pkg::sprite_x0_p2;
		return (mode == battle_pkg::draw_message) ? int'(battle_pkg::msg_x0) : 0;
	endfunction

	function automatic int y_offset(input battle_pkg::draw_t mode);
		if (mode == battle_pkg::draw_sprite_p1 || mode == battle_pkg::draw_sprite_p2)
			return battle_pkg::sprite_y0;
		return (mode == battle_pkg::draw_message) ? int'(battle_pkg::msg_y0) : 0;
	endfunction

	assign exp_seg_p1 = expected_segments(exp_p1_species);
	assign exp_seg_p2 = expected_segments(exp_p2_species);

	// battle chain model, one stage per register
	always @(posedge clock)
	begin
		if (!resetn)
		begin
			exp_p1_species <= battle_pkg::species_none;
			exp_p2_species <= battle_pkg::species_none;
			exp_msg <= battle_pkg::msg_none;
			hit_q <= 1'b0;
			exp_p1_health <= battle_pkg::health_full;
			exp_p2_health <= battle_pkg::health_full;
			exp_p1_wins <= 1'b0;
			exp_p2_wins <= 1'b0;
		end
		else
		begin
			if (p1_pick)
				exp_p1_species <= pick_species;
			if (p2_pick)
				exp_p2_species <= pick_species;
			hit_q <= p1_tackle || p1_special || p2_tackle || p2_special;
			// player 1 strikes first on a tie
			if (p1_tackle || p1_special)
			begin
				to_p2_q <= 1'b1;
				amount_q <= attack_damage(exp_p1_species, exp_p2_species, p1_special);
				exp_msg <= attack_message(exp_p1_species, exp_p2_species, p1_special);
			end
			else if (p2_tackle || p2_special)
			begin
				to_p2_q <= 1'b0;
				amount_q <= attack_damage(exp_p2_species, exp_p1_species, p2_special);
				exp_msg <= attack_message(exp_p2_species, exp_p1_species, p2_special);
			end
			if (p1_pick)
			begin
				exp_p1_health <= battle_pkg::health_full;
				exp_p2_health <= battle_pkg::health_full;
			end
			else if (hit_q && to_p2_q)
				exp_p2_health <= health_after(exp_p2_health, amount_q);
			else if (hit_q)
				exp_p1_health <= health_after(exp_p1_health, amount_q);
			exp_p1_wins <= (exp_p2_health == 4'd0);
			exp_p2_wins <= (exp_p2_health != 4'd0) && (exp_p1_health == 4'd0);
		end
	end

	// raster model, counter restarts when the area changes or goes idle
	always @(posedge clock)
	begin : raster_model
		int area;
		int cur_x;
		int cur_y;
		area = area_of(draw_mode);
		cur_x = (scan_area == area) ? scan_x : 0;
		cur_y = (scan_area == area) ? scan_y : 0;
		if (!resetn)
		begin
			exp_valid <= 1'b0;
			scan_area <= 0;
			scan_x <= 0;
			scan_y <= 0;
		end
		else
		begin
			exp_valid <= (area != 0);
			exp_x <= 8'(cur_x + x_offset(draw_mode));
			exp_y <= 7'(cur_y + y_offset(draw_mode));
			exp_colour <= colour_of_mode(draw_mode);
			exp_shown <= draw_mode;
			scan_area <= area;
			scan_x <= (area == 0 || cur_x == area_width(area) - 1) ? 0 : cur_x + 1;
			if (area == 0)
				scan_y <= 0;
			else if (cur_x == area_width(area) - 1)
				scan_y <= (cur_y == area_height(area) - 1) ? 0 : cur_y + 1;
		end
	end

	check_seg_p1: assert property (@(posedge clock) disable iff (!resetn) pokemon_p1 == exp_seg_p1)
		else report_mismatch("pokemon_p1", pokemon_p1, exp_seg_p1);
	check_seg_p2: assert property (@(posedge clock) disable iff (!resetn) pokemon_p2 == exp_seg_p2)
		else report_mismatch("pokemon_p2", pokemon_p2, exp_seg_p2);
	check_health_p1: assert property (@(posedge clock) disable iff (!resetn)
		display_p1_health == exp_p1_health)
		else report_mismatch("display_p1_health", display_p1_health, exp_p1_health);
	check_health_p2: assert property (@(posedge clock) disable iff (!resetn)
		display_p2_health == exp_p2_health)
		else report_mismatch("display_p2_health", display_p2_health, exp_p2_health);
	check_p1_wins: assert property (@(posedge clock) disable iff (!resetn) p1_wins == exp_p1_wins)
		else report_mismatch("p1_wins", p1_wins, exp_p1_wins);
	check_p2_wins: assert property (@(posedge clock) disable iff (!resetn) p2_wins == exp_p2_wins)
		else report_mismatch("p2_wins", p2_wins, exp_p2_wins);
	check_valid: assert property (@(posedge clock) disable iff (!resetn) pixel_valid == exp_valid)
		else report_mismatch("pixel_valid", pixel_valid, exp_valid);
	check_x: assert property (@(posedge clock) disable iff (!resetn) exp_valid |-> x_data == exp_x)
		else report_mismatch("x_data", x_data, exp_x);
	check_y: assert property (@(posedge clock) disable iff (!resetn) exp_valid |-> y_data == exp_y)
		else report_mismatch("y_data", y_data, exp_y);
	check_colour: assert property (@(posedge clock) disable iff (!resetn)
		exp_valid |-> colour == exp_colour)
		else report_mismatch("colour", colour, exp_colour);
	check_msg_area: assert property (@(posedge clock) disable iff (!resetn)
		(pixel_valid && exp_shown == battle_pkg::draw_message) |->
		(x_data >= battle_pkg::msg_x0 && x_data < battle_pkg::msg_x0 + battle_pkg::msg_w &&
		y_data >= battle_pkg::msg_y0 && y_data < battle_pkg::msg_y0 + battle_pkg::msg_h))
		else report_failure("a message pixel landed outside the message area");

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
		$display("TEST FAIL");
		$fatal(1, "value mismatch on %s", name);
	endtask

	task automatic report_failure(input string what);
		$display("%s at %0t ns", what, $time);
		$display("TEST FAIL");
		$fatal(1, "%s", what);
	endtask

	task automatic random_bits(input int count, output logic [31:0] value);
		int i;
		value = '0;
		for (i = 0; i < count; i++)
		begin
			lfsr = lfsr_step(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic start_round();
		logic [31:0] bits;
		random_bits(4, bits);
		@(posedge clock);
		p1_pick <= 1'b1;
		pick_species <= battle_pkg::species_t'(bits[3:2]);
		@(posedge clock);
		p1_pick <= 1'b0;
		p2_pick <= 1'b1;
		pick_species <= battle_pkg::species_t'(bits[1:0]);
		@(posedge clock);
		p2_pick <= 1'b0;
		// old win flags drop one cycle after health is restored
		@(posedge clock);
	endtask

	task automatic fight_until_win();
		logic [31:0] bits;
		int turns;
		turns = 0;
		while (!(p1_wins || p2_wins) && turns < 200)
		begin
			random_bits(4, bits);
			@(posedge clock);
			p1_tackle <= (bits[3:2] == 2'd1);
			p1_special <= (bits[3:2] == 2'd2);
			p2_tackle <= (bits[1:0] == 2'd1);
			p2_special <= (bits[1:0] == 2'd2);
			turns++;
		end
		@(posedge clock);
		p1_tackle <= 1'b0;
		p1_special <= 1'b0;
		p2_tackle <= 1'b0;
		p2_special <= 1'b0;
		if (!(p1_wins || p2_wins))
			report_failure("no win flag rose within 200 attack turns");
	endtask

	task automatic show_mode(input battle_pkg::draw_t mode, input int cycles);
		int waited;
		@(posedge clock);
		draw_mode <= mode;
		waited = 0;
		while (!pixel_valid && waited < 4)
		begin
			@(posedge clock);
			waited++;
		end
		if (!pixel_valid)
			report_failure("pixel_valid did not rise after a draw mode was selected");
		repeat (cycles) @(posedge clock);
		draw_mode <= battle_pkg::draw_idle;
		@(posedge clock);
	endtask

	initial
	begin
		int round;
		lfsr = 32'haf97_d501;
		resetn <= 1'b0;
		p1_pick <= 1'b0;
		p2_pick <= 1'b0;
		pick_species <= battle_pkg::species_none;
		p1_tackle <= 1'b0;
		p1_special <= 1'b0;
		p2_tackle <= 1'b0;
		p2_special <= 1'b0;
		draw_mode <= battle_pkg::draw_idle;
		repeat (2) @(posedge clock);
		resetn <= 1'b1;
		// screens before any battle, no message and no winner yet
		show_mode(battle_pkg::draw_message, 40);
		show_mode(battle_pkg::draw_winner, 40);
		for (round = 0; round < 8; round++)
		begin
			start_round();
			fight_until_win();
			show_mode(battle_pkg::draw_sprite_p1, 30);
			show_mode(battle_pkg::draw_sprite_p2, 30);
			show_mode(battle_pkg::draw_message, 30);
			show_mode(battle_pkg::draw_winner, 30);
		end
		// each area long enough to wrap
		show_mode(battle_pkg::draw_sprite_p1, battle_pkg::sprite_w * battle_pkg::sprite_h + 70);
		show_mode(battle_pkg::draw_sprite_p2, battle_pkg::sprite_w * battle_pkg::sprite_h + 70);
		show_mode(battle_pkg::draw_message, battle_pkg::msg_w * battle_pkg::msg_h + 160);
		show_mode(battle_pkg::draw_background, battle_pkg::screen_w * battle_pkg::screen_h + 170);
		show_mode(battle_pkg::draw_winner, battle_pkg::screen_w * battle_pkg::screen_h + 170);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== battle_datapath.f ====
verilog/battle_pkg.sv
verilog/species_select.sv
verilog/damage_calc.sv
verilog/health_keeper.sv
verilog/region_scanner.sv
verilog/pixel_painter.sv
verilog/battle_datapath.sv
sim/tb_battle.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_battle \
	-f battle_datapath.f

./obj_dir/Vtb_battle
